// File: bench/clk_gen.sv
`default_nettype none
`timescale 1ns/1ps

module clk_gen (
	input  wire  i_restart,
	output logic o_clk,
	output logic o_arst_n
);

	// reset held for 4 rising edges, released on a falling edge
	logic [2:0] cnt = 3'd0;

	initial begin
		o_clk = 1'b0;
		forever #10 o_clk = ~o_clk;
	end

	always @(negedge o_clk or posedge i_restart) begin
		if (i_restart) begin
			cnt <= 3'd0;
		end else if (cnt < 3'd4) begin
			cnt <= cnt + 3'd1;
		end
	end

	assign o_arst_n = (cnt == 3'd4);

endmodule

`default_nettype wire

// File: bench/tb_core.sv
`default_nettype none
`timescale 1ns/1ps

module tb_core
	import mips_isa_pkg::*;
();

	localparam int    N_PROGS       = 5;
	localparam int    N_BLOCKS      = 40;
	localparam int    SETTLE_CYCLES = 20;
	localparam word_t SEED          = 32'h8ef98486;

	logic  clk;
	logic  arst_n;
	logic  restart;
	word_t read_instruction;
	word_t read_data;
	word_t instruction_address;
	word_t data_address;
	word_t write_data;
	logic  mem_write;
	logic  mem_read;

	word_t    imem [0:511];
	word_t    dmem [0:63];
	word_t    model_dmem [0:63];
	word_t    exp_addr_q [$];
	word_t    exp_data_q [$];
	word_t    rng;
	word_t    halt_pc;
	reg_idx_t last_rd;
	int       plen;
	int       n_exec;
	int       limit;
	int       cycles;
	int       prog_idx;
	int       store_idx;

	clk_gen u_clk_gen (
		.i_restart (restart),
		.o_clk     (clk),
		.o_arst_n  (arst_n)
	);

	core u_core (
		.i_clk                 (clk),
		.i_arst_n              (arst_n),
		.i_read_instruction    (read_instruction),
		.i_read_data           (read_data),
		.o_instruction_address (instruction_address),
		.o_data_address        (data_address),
		.o_write_data          (write_data),
		.o_mem_write           (mem_write),
		.o_mem_read            (mem_read)
	);

	// both memories answer in the same cycle
	assign read_instruction = imem[instruction_address[10:2]];
	assign read_data        = dmem[data_address[7:2]];

	function automatic word_t xorshift32();
		word_t x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	function automatic reg_idx_t rand_reg();
		return 5'(32'd1 + (xorshift32() % 32'd15));
	endfunction

	function automatic logic [15:0] rand_off();
		return 16'((xorshift32() % 32'd64) << 2);
	endfunction

	function automatic word_t enc_r(input logic [5:0] funct, input reg_idx_t rd,
			input reg_idx_t rs, input reg_idx_t rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic word_t enc_i(input logic [5:0] op, input reg_idx_t rs,
			input reg_idx_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t enc_j(input logic [5:0] op, input word_t target);
		return {op, target[27:2]};
	endfunction

	function automatic word_t dmem_fill(input logic [5:0] idx);
		return ({26'd0, idx} * 32'h9e3779b1) ^ {idx, idx, idx, idx, idx, 2'b10};
	endfunction

	task automatic stop_on_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_store(input string name, input word_t exp_addr,
			input word_t exp_data, input word_t act_addr, input word_t act_data);
		if (exp_addr !== act_addr || exp_data !== act_data) begin
			$display("FAIL %s: expected addr %h data %h, actual addr %h data %h",
				name, exp_addr, exp_data, act_addr, act_data);
			stop_on_failure();
		end
	endtask

	task automatic check_ctrl(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic emit(input word_t w);
		imem[9'(plen)] = w;
		plen++;
	endtask

	// one random ALU or immediate instruction
	task automatic gen_alu(input reg_idx_t rd, input reg_idx_t rs, input reg_idx_t rt);
		word_t       r;
		logic [3:0]  sel;
		logic [15:0] imm;
		r = xorshift32();
		sel = 4'(r[7:0] % 8'd12);
		imm = r[31:16];
		case (sel)
			4'd0: emit(enc_r(FN_ADDU, rd, rs, rt));
			4'd1: emit(enc_r(FN_SUBU, rd, rs, rt));
			4'd2: emit(enc_r(FN_AND, rd, rs, rt));
			4'd3: emit(enc_r(FN_OR, rd, rs, rt));
			4'd4: emit(enc_r(FN_XOR, rd, rs, rt));
			4'd5: emit(enc_r(FN_SLT, rd, rs, rt));
			4'd6: emit(enc_i(OP_ADDIU, rs, rd, imm));
			4'd7: emit(enc_i(OP_SLTI, rs, rd, imm));
			4'd8: emit(enc_i(OP_ANDI, rs, rd, imm));
			4'd9: emit(enc_i(OP_ORI, rs, rd, imm));
			4'd11: emit(enc_i(OP_LUI, 5'd0, rd, imm));
			default: emit(enc_i(OP_XORI, rs, rd, imm));
		endcase
	endtask

	// chained on the previous result
	task automatic blk_alu();
		word_t    r;
		reg_idx_t rd;
		reg_idx_t rt;
		r = xorshift32();
		rd = rand_reg();
		rt = r[0] ? last_rd : rand_reg();
		gen_alu(rd, last_rd, rt);
		last_rd = rd;
		if (r[4:2] == 3'd0) begin
			emit(enc_i(OP_SW, 5'd0, rd, rand_off()));
		end
	endtask

	task automatic blk_load();
		word_t       r;
		logic [15:0] off;
		reg_idx_t    dst;
		reg_idx_t    use_rd;
		r = xorshift32();
		off = rand_off();
		dst = rand_reg();
		use_rd = rand_reg();
		emit(enc_i(OP_SW, 5'd0, rand_reg(), off));
		if (r[0]) begin
			blk_alu();
		end
		emit(enc_i(OP_LW, 5'd0, dst, off));
		if (r[1]) begin
			// loaded value goes straight out as store data
			emit(enc_i(OP_SW, 5'd0, dst, rand_off()));
		end else begin
			gen_alu(use_rd, dst, r[2] ? dst : rand_reg());
			last_rd = use_rd;
			emit(enc_i(OP_SW, 5'd0, use_rd, rand_off()));
		end
	endtask

	task automatic blk_ctrl();
		word_t    r;
		int       k;
		int       base;
		reg_idx_t a;
		reg_idx_t b;
		r = xorshift32();
		k = 1 + int'(r[9:8] % 2'd3);
		case (r[1:0])
			2'd0, 2'd1: begin
				a = rand_reg();
				if (r[4]) begin
					emit(enc_i(OP_LW, 5'd0, a, rand_off()));
				end else if (r[5]) begin
					gen_alu(a, last_rd, rand_reg());
					last_rd = a;
				end
				b = r[6] ? a : rand_reg();
				emit(enc_i(r[0] ? OP_BNE : OP_BEQ, a, b, 16'(k + 1)));
				gen_alu(rand_reg(), rand_reg(), rand_reg());
				for (int i = 0; i < k; i++) begin
					gen_alu(rand_reg(), rand_reg(), rand_reg());
				end
			end
			2'd2: begin
				emit(enc_j(OP_J, 32'((plen + 2 + k) * 4)));
				gen_alu(rand_reg(), rand_reg(), rand_reg());
				for (int i = 0; i < k; i++) begin
					gen_alu(rand_reg(), rand_reg(), rand_reg());
				end
			end
			default: begin
				// jal to a short subroutine after a j that skips it
				base = plen;
				emit(enc_j(OP_JAL, 32'((base + 4) * 4)));
				if (r[4]) begin
					emit(enc_i(OP_SW, 5'd0, REG_LINK, rand_off()));
				end else begin
					gen_alu(rand_reg(), rand_reg(), rand_reg());
				end
				emit(enc_j(OP_J, 32'((base + 7) * 4)));
				gen_alu(rand_reg(), rand_reg(), rand_reg());
				if (r[5]) begin
					emit(enc_i(OP_SW, 5'd0, REG_LINK, rand_off()));
				end else begin
					gen_alu(rand_reg(), rand_reg(), rand_reg());
				end
				emit(enc_r(FN_JR, 5'd0, REG_LINK, 5'd0));
				gen_alu(rand_reg(), rand_reg(), rand_reg());
			end
		endcase
	endtask

	task automatic build_program(input int p);
		word_t r;
		plen = 0;
		for (int i = 1; i <= 15; i++) begin
			emit(enc_i(OP_LUI, 5'd0, 5'(i), 16'(xorshift32())));
			emit(enc_i(OP_ORI, 5'(i), 5'(i), 16'(xorshift32())));
		end
		last_rd = 5'd1;
		for (int blk = 0; blk < N_BLOCKS; blk++) begin
			r = xorshift32();
			case (p)
				0: blk_alu();
				1: if (blk % 2 == 1) blk_load(); else blk_alu();
				2: blk_ctrl();
				default: begin
					if (r % 32'd3 == 32'd0) begin
						blk_alu();
					end else if (r % 32'd3 == 32'd1) begin
						blk_load();
					end else begin
						blk_ctrl();
					end
				end
			endcase
		end
		for (int i = 1; i <= 15; i++) begin
			emit(enc_i(OP_SW, 5'd0, 5'(i), 16'(i * 4)));
		end
		halt_pc = 32'(plen * 4);
		emit(enc_j(OP_J, halt_pc));
		emit(NOP_WORD);
	endtask

	// instruction-level model with one delay slot
	task automatic run_model();
		word_t      r [0:31];
		word_t      pc;
		word_t      npc;
		word_t      nnpc;
		word_t      ins;
		word_t      a;
		word_t      b;
		word_t      imm_s;
		word_t      imm_z;
		word_t      addr;
		word_t      res;
		logic [5:0] op;
		reg_idx_t   wr;
		logic       wen;
		for (int i = 0; i < 32; i++) begin
			r[i] = '0;
		end
		for (int i = 0; i < 64; i++) begin
			model_dmem[i] = dmem[i];
		end
		exp_addr_q.delete();
		exp_data_q.delete();
		pc = RESET_PC;
		npc = pc + 32'd4;
		n_exec = 0;
		while (pc != halt_pc && n_exec < 4000) begin
			ins = imem[pc[10:2]];
			op = ins[31:26];
			a = r[ins[25:21]];
			b = r[ins[20:16]];
			imm_s = {{16{ins[15]}}, ins[15:0]};
			imm_z = {16'h0000, ins[15:0]};
			nnpc = npc + 32'd4;
			wr = ins[20:16];
			wen = 1'b1;
			res = '0;
			addr = a + imm_s;
			case (op)
				OP_RTYPE: begin
					wr = ins[15:11];
					case (ins[5:0])
						FN_ADDU: res = a + b;
						FN_SUBU: res = a - b;
						FN_AND:  res = a & b;
						FN_OR:   res = a | b;
						FN_XOR:  res = a ^ b;
						FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
						FN_JR: begin
							wen = 1'b0;
							nnpc = a;
						end
						default: wen = 1'b0;
					endcase
				end
				OP_ADDIU: res = a + imm_s;
				OP_SLTI:  res = {31'd0, $signed(a) < $signed(imm_s)};
				OP_ANDI:  res = a & imm_z;
				OP_ORI:   res = a | imm_z;
				OP_XORI:  res = a ^ imm_z;
				OP_LUI:   res = {ins[15:0], 16'h0000};
				OP_LW:    res = model_dmem[addr[7:2]];
				OP_SW: begin
					wen = 1'b0;
					model_dmem[addr[7:2]] = b;
					exp_addr_q.push_back(addr);
					exp_data_q.push_back(b);
				end
				OP_BEQ, OP_BNE: begin
					wen = 1'b0;
					if ((a == b) == (op == OP_BEQ)) begin
						nnpc = pc + 32'd4 + (imm_s << 2);
					end
				end
				OP_J, OP_JAL: begin
					wen = (op == OP_JAL);
					wr = REG_LINK;
					res = pc + 32'd8;
					nnpc = {pc[31:28], ins[25:0], 2'b00};
				end
				default: wen = 1'b0;
			endcase
			if (wen && wr != 5'd0) begin
				r[wr] = res;
			end
			pc = npc;
			npc = nnpc;
			n_exec++;
		end
		if (pc != halt_pc) begin
			$display("model did not reach the halt address of program %0d", prog_idx);
			stop_on_failure();
		end
	endtask

	task automatic fill_memories();
		for (int i = 0; i < 512; i++) begin
			imem[i] = NOP_WORD;
		end
		for (int i = 0; i < 64; i++) begin
			dmem[i] = dmem_fill(6'(i));
		end
	endtask

	// checks every cycle of reset and the first one after it
	task automatic check_reset(input int p);
		string name;
		name = $sformatf("prog%0d reset", p);
		while (arst_n !== 1'b1) begin
			@(negedge clk);
			#1;
			check_ctrl({name, " mem_write"}, 1'b0, mem_write);
			check_ctrl({name, " mem_read"}, 1'b0, mem_read);
			check_word({name, " pc"}, RESET_PC, instruction_address);
		end
	endtask

	task automatic record_store(input word_t addr, input word_t data);
		string name;
		word_t ea;
		word_t ed;
		if (exp_addr_q.size() == 0) begin
			$display("program %0d wrote %h to %h after its last expected store",
				prog_idx, data, addr);
			stop_on_failure();
		end else begin
			name = $sformatf("prog%0d store%0d", prog_idx, store_idx);
			ea = exp_addr_q.pop_front();
			ed = exp_data_q.pop_front();
			check_store(name, ea, ed, addr, data);
			dmem[addr[7:2]] = data;
			store_idx++;
		end
	endtask

	always @(posedge clk) begin
		if (arst_n === 1'b1 && mem_write === 1'b1) begin
			record_store(data_address, write_data);
		end
	end

	initial begin
		restart = 1'b0;
		rng = SEED;
		prog_idx = 0;
		store_idx = 0;
		for (int p = 0; p < N_PROGS; p++) begin
			if (p != 0) begin
				@(negedge clk);
				restart = 1'b1;
			end
			prog_idx = p;
			store_idx = 0;
			fill_memories();
			build_program(p);
			run_model();
			limit = 4 * n_exec + 50;
			#1;
			restart = 1'b0;
			check_reset(p);
			cycles = 0;
			while (exp_addr_q.size() != 0) begin
				@(negedge clk);
				cycles++;
				if (cycles > limit) begin
					$display("timeout in program %0d, %0d stores still missing after %0d cycles",
						p, exp_addr_q.size(), cycles);
					stop_on_failure();
				end
			end
			// any store from here on is caught by the monitor
			repeat (SETTLE_CYCLES) @(negedge clk);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
verilog/mips_isa_pkg.sv
verilog/core_ctrl_pkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/mem_stage.sv
verilog/core.sv
bench/clk_gen.sv
bench/tb_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_core \
	-f list.f --Mdir obj_dir -o tb_core_sim

./obj_dir/tb_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	exit 0
else
	exit 1
fi

// File: verilog/core.sv
`default_nettype none
`timescale 1ns/1ps

module core
	import mips_isa_pkg::*, core_ctrl_pkg::*;
(
	input  wire        i_clk,
	input  wire        i_arst_n,
	input  wire word_t i_read_instruction,
	input  wire word_t i_read_data,
	output word_t      o_instruction_address,
	output word_t      o_data_address,
	output word_t      o_write_data,
	output logic       o_mem_write,
	output logic       o_mem_read
);

	// fetch to decode
	word_t id_pc4;
	word_t id_instr;
	logic  id_stall;
	logic  id_redirect;
	word_t id_target;

	// decode to execute
	word_t    ex_rs_data;
	word_t    ex_rt_data;
	word_t    ex_imm;
	reg_idx_t ex_rs;
	reg_idx_t ex_rt;
	reg_idx_t ex_rd;
	word_t    ex_link;
	alu_op_t  ex_alu_op;
	logic     ex_alu_imm;
	logic     ex_reg_dst;
	logic     ex_mem_read;
	logic     ex_mem_write;
	wb_src_t  ex_wb_src;
	logic     ex_reg_write;
	fwd_sel_t ex_fwd_a;
	fwd_sel_t ex_fwd_b;

	// execute hazard feedback
	reg_idx_t ex_dst;
	logic     ex_we;
	logic     ex_load;

	// execute to mem_stage
	word_t    mem_result;
	word_t    mem_store_data;
	reg_idx_t mem_rd;
	word_t    mem_link;
	logic     mem_read;
	logic     mem_write;
	wb_src_t  mem_wb_src;
	logic     mem_reg_write;

	// mem_stage feedback
	reg_idx_t mem_fb_rd;
	logic     mem_fb_we;
	logic     mem_fb_load;
	logic     wb_we;
	reg_idx_t wb_rd;
	word_t    wb_data;

	fetch u_fetch (
		.i_clk              (i_clk),
		.i_arst_n           (i_arst_n),
		.i_stall            (id_stall),
		.i_redirect         (id_redirect),
		.i_target           (id_target),
		.i_read_instruction (i_read_instruction),
		.o_pc               (o_instruction_address),
		.o_pc4              (id_pc4),
		.o_instr            (id_instr)
	);

	decode u_decode (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_pc4        (id_pc4),
		.i_instr      (id_instr),
		.i_wb_we      (wb_we),
		.i_wb_rd      (wb_rd),
		.i_wb_data    (wb_data),
		.i_ex_rd      (ex_dst),
		.i_ex_we      (ex_we),
		.i_ex_load    (ex_load),
		.i_mem_rd     (mem_fb_rd),
		.i_mem_we     (mem_fb_we),
		.i_mem_load   (mem_fb_load),
		.i_mem_result (mem_result),
		.o_stall      (id_stall),
		.o_redirect   (id_redirect),
		.o_target     (id_target),
		.o_rs_data    (ex_rs_data),
		.o_rt_data    (ex_rt_data),
		.o_imm        (ex_imm),
		.o_rs         (ex_rs),
		.o_rt         (ex_rt),
		.o_rd         (ex_rd),
		.o_link       (ex_link),
		.o_alu_op     (ex_alu_op),
		.o_alu_imm    (ex_alu_imm),
		.o_reg_dst    (ex_reg_dst),
		.o_mem_read   (ex_mem_read),
		.o_mem_write  (ex_mem_write),
		.o_wb_src     (ex_wb_src),
		.o_reg_write  (ex_reg_write),
		.o_fwd_a      (ex_fwd_a),
		.o_fwd_b      (ex_fwd_b)
	);

	execute u_execute (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_rs_data    (ex_rs_data),
		.i_rt_data    (ex_rt_data),
		.i_imm        (ex_imm),
		.i_rs         (ex_rs),
		.i_rt         (ex_rt),
		.i_rd         (ex_rd),
		.i_link       (ex_link),
		.i_alu_op     (ex_alu_op),
		.i_alu_imm    (ex_alu_imm),
		.i_reg_dst    (ex_reg_dst),
		.i_mem_read   (ex_mem_read),
		.i_mem_write  (ex_mem_write),
		.i_wb_src     (ex_wb_src),
		.i_reg_write  (ex_reg_write),
		.i_fwd_a      (ex_fwd_a),
		.i_fwd_b      (ex_fwd_b),
		.i_mem_result (mem_result),
		.i_wb_data    (wb_data),
		.o_alu_result (mem_result),
		.o_store_data (mem_store_data),
		.o_rd         (mem_rd),
		.o_link       (mem_link),
		.o_mem_read   (mem_read),
		.o_mem_write  (mem_write),
		.o_wb_src     (mem_wb_src),
		.o_reg_write  (mem_reg_write),
		.o_ex_rd      (ex_dst),
		.o_ex_we      (ex_we),
		.o_ex_load    (ex_load)
	);

	mem_stage u_mem_stage (
		.i_clk          (i_clk),
		.i_arst_n       (i_arst_n),
		.i_alu_result   (mem_result),
		.i_store_data   (mem_store_data),
		.i_rd           (mem_rd),
		.i_link         (mem_link),
		.i_mem_read     (mem_read),
		.i_mem_write    (mem_write),
		.i_wb_src       (mem_wb_src),
		.i_reg_write    (mem_reg_write),
		.i_read_data    (i_read_data),
		.o_data_address (o_data_address),
		.o_write_data   (o_write_data),
		.o_mem_read_en  (o_mem_read),
		.o_mem_write_en (o_mem_write),
		.o_mem_rd       (mem_fb_rd),
		.o_mem_we       (mem_fb_we),
		.o_mem_load     (mem_fb_load),
		.o_wb_we        (wb_we),
		.o_wb_rd        (wb_rd),
		.o_wb_data      (wb_data)
	);

endmodule

`default_nettype wire

// File: verilog/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

	// ALU function chosen in decode
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} alu_op_t;

	// operand source for execute, resolved one stage early
	typedef enum logic [1:0] {
		FWD_RF,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	// what lands in the register file
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_LINK
	} wb_src_t;

endpackage

`default_nettype wire

// File: verilog/decode.sv
`default_nettype none
`timescale 1ns/1ps

module decode
	import mips_isa_pkg::*, core_ctrl_pkg::*;
(
	input  wire           i_clk,
	input  wire           i_arst_n,
	input  wire word_t    i_pc4,
	input  wire word_t    i_instr,
	input  wire           i_wb_we,
	input  wire reg_idx_t i_wb_rd,
	input  wire word_t    i_wb_data,
	input  wire reg_idx_t i_ex_rd,
	input  wire           i_ex_we,
	input  wire           i_ex_load,
	input  wire reg_idx_t i_mem_rd,
	input  wire           i_mem_we,
	input  wire           i_mem_load,
	input  wire word_t    i_mem_result,
	output logic          o_stall,
	output logic          o_redirect,
	output word_t         o_target,
	output word_t         o_rs_data,
	output word_t         o_rt_data,
	output word_t         o_imm,
	output reg_idx_t      o_rs,
	output reg_idx_t      o_rt,
	output reg_idx_t      o_rd,
	output word_t         o_link,
	output alu_op_t       o_alu_op,
	output logic          o_alu_imm,
	output logic          o_reg_dst,
	output logic          o_mem_read,
	output logic          o_mem_write,
	output wb_src_t       o_wb_src,
	output logic          o_reg_write,
	output fwd_sel_t      o_fwd_a,
	output fwd_sel_t      o_fwd_b
);

	logic [5:0] op;
	logic [5:0] funct;
	reg_idx_t   rs;
	reg_idx_t   rt;
	reg_idx_t   rd_field;
	reg_idx_t   dst;
	word_t      imm_ext;

	// decoded controls
	alu_op_t alu_op;
	wb_src_t wb_src;
	logic    alu_imm;
	logic    reg_dst;
	logic    mem_rd;
	logic    mem_wr;
	logic    we;
	logic    zext;
	logic    use_rs;
	logic    use_rt;
	logic    is_beq;
	logic    is_bne;
	logic    is_j;
	logic    is_jal;
	logic    is_jr;
	logic    reg_write;

	word_t rf [1:31];
	word_t rf_rs;
	word_t rf_rt;
	word_t br_rs;
	word_t br_rt;

	logic rs_hit_ex;
	logic rt_hit_ex;
	logic rs_hit_mem;
	logic rt_hit_mem;
	logic is_br;
	logic taken;

	assign op       = i_instr[31:26];
	assign rs       = i_instr[25:21];
	assign rt       = i_instr[20:16];
	assign rd_field = i_instr[15:11];
	assign funct    = i_instr[5:0];

	always_comb begin
		alu_op  = ALU_ADD;
		wb_src  = WB_ALU;
		alu_imm = 1'b0;
		reg_dst = 1'b0;
		mem_rd  = 1'b0;
		mem_wr  = 1'b0;
		we      = 1'b0;
		zext    = 1'b0;
		use_rs  = 1'b0;
		use_rt  = 1'b0;
		is_beq  = 1'b0;
		is_bne  = 1'b0;
		is_j    = 1'b0;
		is_jal  = 1'b0;
		is_jr   = 1'b0;
		case (op)
			OP_RTYPE: begin
				reg_dst = 1'b1;
				use_rs  = 1'b1;
				use_rt  = 1'b1;
				we      = 1'b1;
				case (funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_JR: begin
						we     = 1'b0;
						use_rt = 1'b0;
						is_jr  = 1'b1;
					end
					// sll zero and anything else unsupported does nothing
					default: begin
						we     = 1'b0;
						use_rs = 1'b0;
						use_rt = 1'b0;
					end
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				alu_imm = 1'b1;
				we      = 1'b1;
				use_rs  = (op != OP_LUI);
				zext    = (op == OP_ANDI) || (op == OP_ORI) ||
				          (op == OP_XORI) || (op == OP_LUI);
				case (op)
					OP_SLTI: alu_op = ALU_SLT;
					OP_ANDI: alu_op = ALU_AND;
					OP_ORI:  alu_op = ALU_OR;
					OP_XORI: alu_op = ALU_XOR;
					OP_LUI:  alu_op = ALU_LUI;
					default: alu_op = ALU_ADD;
				endcase
			end
			OP_LW: begin
				alu_imm = 1'b1;
				use_rs  = 1'b1;
				mem_rd  = 1'b1;
				we      = 1'b1;
				wb_src  = WB_MEM;
			end
			OP_SW: begin
				alu_imm = 1'b1;
				use_rs  = 1'b1;
				use_rt  = 1'b1;
				mem_wr  = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				is_beq = (op == OP_BEQ);
				is_bne = (op == OP_BNE);
			end
			OP_J: is_j = 1'b1;
			OP_JAL: begin
				is_j    = 1'b1;
				is_jal  = 1'b1;
				we      = 1'b1;
				reg_dst = 1'b1;
				wb_src  = WB_LINK;
			end
			default: ;
		endcase
	end

	assign imm_ext = zext ? {16'h0000, i_instr[15:0]} : {{16{i_instr[15]}}, i_instr[15:0]};

	// writes to r0 are dropped here so nothing downstream forwards them
	assign dst       = is_jal ? REG_LINK : (reg_dst ? rd_field : rt);
	assign reg_write = we && (dst != '0);

	// r0 reads as zero and writeback passes straight through
	always_ff @(posedge i_clk) begin
		if (i_wb_we && i_wb_rd != '0) begin
			rf[i_wb_rd] <= i_wb_data;
		end
	end

	assign rf_rs = (rs == '0) ? '0 : ((i_wb_we && i_wb_rd == rs) ? i_wb_data : rf[rs]);
	assign rf_rt = (rt == '0) ? '0 : ((i_wb_we && i_wb_rd == rt) ? i_wb_data : rf[rt]);

	// compare operands see the memory stage too
	assign rs_hit_mem = i_mem_we && (i_mem_rd == rs);
	assign rt_hit_mem = i_mem_we && (i_mem_rd == rt);
	assign br_rs      = rs_hit_mem ? i_mem_result : rf_rs;
	assign br_rt      = rt_hit_mem ? i_mem_result : rf_rt;

	// hazards
	assign rs_hit_ex = use_rs && i_ex_we && (i_ex_rd == rs);
	assign rt_hit_ex = use_rt && i_ex_we && (i_ex_rd == rt);
	assign is_br     = is_beq || is_bne || is_jr;
	assign o_stall   = (i_ex_load && (rs_hit_ex || rt_hit_ex)) ||
	                   (is_br && (rs_hit_ex || rt_hit_ex)) ||
	                   (is_br && i_mem_load &&
	                    ((use_rs && rs_hit_mem) || (use_rt && rt_hit_mem)));

	assign taken = (is_beq && br_rs == br_rt) || (is_bne && br_rs != br_rt) ||
	               is_j || is_jr;
	assign o_redirect = taken && !o_stall;

	always_comb begin
		if (is_jr) begin
			o_target = br_rs;
		end else if (is_j) begin
			o_target = {i_pc4[31:28], i_instr[25:0], 2'b00};
		end else begin
			o_target = i_pc4 + {imm_ext[29:0], 2'b00};
		end
	end

	// a stall turns the ID/EX controls into a bubble
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_mem_read  <= 1'b0;
			o_mem_write <= 1'b0;
			o_reg_write <= 1'b0;
		end else begin
			o_mem_read  <= mem_rd && !o_stall;
			o_mem_write <= mem_wr && !o_stall;
			o_reg_write <= reg_write && !o_stall;
		end
	end

	// ID/EX payload
	always_ff @(posedge i_clk) begin
		o_rs_data <= rf_rs;
		o_rt_data <= rf_rt;
		o_imm     <= imm_ext;
		o_rs      <= rs;
		o_rt      <= rt;
		o_rd      <= is_jal ? REG_LINK : rd_field;
		o_link    <= i_pc4 + 32'd4;
		o_alu_op  <= alu_op;
		o_alu_imm <= alu_imm;
		o_reg_dst <= reg_dst;
		o_wb_src  <= wb_src;
		// what is in execute now sits in memory next cycle
		if (i_ex_we && i_ex_rd == rs) begin
			o_fwd_a <= FWD_MEM;
		end else if (rs_hit_mem) begin
			o_fwd_a <= FWD_WB;
		end else begin
			o_fwd_a <= FWD_RF;
		end
		if (i_ex_we && i_ex_rd == rt) begin
			o_fwd_b <= FWD_MEM;
		end else if (rt_hit_mem) begin
			o_fwd_b <= FWD_WB;
		end else begin
			o_fwd_b <= FWD_RF;
		end
	end

	// a branch on a load in execute is the longest hold
	a_stall_bounded: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_stall && $past(o_stall) |=> !o_stall)
		else $error("decode: stall lasted more than two cycles");

endmodule

`default_nettype wire

// File: verilog/execute.sv
`default_nettype none
`timescale 1ns/1ps

module execute
	import mips_isa_pkg::*, core_ctrl_pkg::*;
(
	input  wire           i_clk,
	input  wire           i_arst_n,
	input  wire word_t    i_rs_data,
	input  wire word_t    i_rt_data,
	input  wire word_t    i_imm,
	input  wire reg_idx_t i_rs,
	input  wire reg_idx_t i_rt,
	input  wire reg_idx_t i_rd,
	input  wire word_t    i_link,
	input  wire alu_op_t  i_alu_op,
	input  wire           i_alu_imm,
	input  wire           i_reg_dst,
	input  wire           i_mem_read,
	input  wire           i_mem_write,
	input  wire wb_src_t  i_wb_src,
	input  wire           i_reg_write,
	input  wire fwd_sel_t i_fwd_a,
	input  wire fwd_sel_t i_fwd_b,
	input  wire word_t    i_mem_result,
	input  wire word_t    i_wb_data,
	output word_t         o_alu_result,
	output word_t         o_store_data,
	output reg_idx_t      o_rd,
	output word_t         o_link,
	output logic          o_mem_read,
	output logic          o_mem_write,
	output wb_src_t       o_wb_src,
	output logic          o_reg_write,
	output reg_idx_t      o_ex_rd,
	output logic          o_ex_we,
	output logic          o_ex_load
);

	word_t    op_a;
	word_t    op_b;
	word_t    rt_val;
	word_t    alu_out;
	reg_idx_t dst;

	// forwarding muxes
	always_comb begin
		case (i_fwd_a)
			FWD_MEM: op_a = i_mem_result;
			FWD_WB:  op_a = i_wb_data;
			default: op_a = i_rs_data;
		endcase
		case (i_fwd_b)
			FWD_MEM: rt_val = i_mem_result;
			FWD_WB:  rt_val = i_wb_data;
			default: rt_val = i_rt_data;
		endcase
	end

	assign op_b = i_alu_imm ? i_imm : rt_val;

	always_comb begin
		case (i_alu_op)
			ALU_SUB: alu_out = op_a - op_b;
			ALU_AND: alu_out = op_a & op_b;
			ALU_OR:  alu_out = op_a | op_b;
			ALU_XOR: alu_out = op_a ^ op_b;
			ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
			ALU_LUI: alu_out = {op_b[15:0], 16'h0000};
			default: alu_out = op_a + op_b;
		endcase
	end

	assign dst = i_reg_dst ? i_rd : i_rt;

	// seen by decode for stall and forwarding decisions
	assign o_ex_rd   = dst;
	assign o_ex_we   = i_reg_write;
	assign o_ex_load = i_mem_read;

	// EX/MEM controls
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_mem_read  <= 1'b0;
			o_mem_write <= 1'b0;
			o_reg_write <= 1'b0;
		end else begin
			o_mem_read  <= i_mem_read;
			o_mem_write <= i_mem_write;
			o_reg_write <= i_reg_write;
		end
	end

	// EX/MEM payload
	always_ff @(posedge i_clk) begin
		// jal puts its link on the result so both forward paths carry it
		o_alu_result <= (i_wb_src == WB_LINK) ? i_link : alu_out;
		o_store_data <= rt_val;
		o_rd         <= dst;
		o_link       <= i_link;
		o_wb_src     <= i_wb_src;
	end

	a_no_r0_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_reg_write |-> o_rd != '0)
		else $error("execute: write enabled towards r0");

	// decode only forwards for registers that were really written
	a_fwd_nonzero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_reg_write && i_fwd_a != FWD_RF |-> i_rs != '0)
		else $error("execute: forward selected for rs r0");

endmodule

`default_nettype wire

// File: verilog/fetch.sv
`default_nettype none
`timescale 1ns/1ps

module fetch
	import mips_isa_pkg::*;
(
	input  wire        i_clk,
	input  wire        i_arst_n,
	input  wire        i_stall,
	input  wire        i_redirect,
	input  wire word_t i_target,
	input  wire word_t i_read_instruction,
	output word_t      o_pc,
	output word_t      o_pc4,
	output word_t      o_instr
);

	word_t pc;
	word_t pc_plus4;
	word_t ifid_pc4;
	word_t ifid_instr;

	assign pc_plus4 = pc + 32'd4;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pc         <= RESET_PC;
			ifid_pc4   <= RESET_PC;
			ifid_instr <= NOP_WORD;
		end else if (!i_stall) begin
			// on redirect the delay slot is the word on the bus now,
			// so it still goes into IF/ID and only the PC jumps
			pc         <= i_redirect ? i_target : pc_plus4;
			ifid_pc4   <= pc_plus4;
			ifid_instr <= i_read_instruction;
		end
	end

	assign o_pc    = pc;
	assign o_pc4   = ifid_pc4;
	assign o_instr = ifid_instr;

	// a jr to a bad register value would show up here
	a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		pc[1:0] == 2'b00)
		else $error("fetch: pc %h not word aligned", pc);

endmodule

`default_nettype wire

// File: verilog/mem_stage.sv
`default_nettype none
`timescale 1ns/1ps

module mem_stage
	import mips_isa_pkg::*, core_ctrl_pkg::*;
(
	input  wire           i_clk,
	input  wire           i_arst_n,
	input  wire word_t    i_alu_result,
	input  wire word_t    i_store_data,
	input  wire reg_idx_t i_rd,
	input  wire word_t    i_link,
	input  wire           i_mem_read,
	input  wire           i_mem_write,
	input  wire wb_src_t  i_wb_src,
	input  wire           i_reg_write,
	input  wire word_t    i_read_data,
	output word_t         o_data_address,
	output word_t         o_write_data,
	output logic          o_mem_read_en,
	output logic          o_mem_write_en,
	output reg_idx_t      o_mem_rd,
	output logic          o_mem_we,
	output logic          o_mem_load,
	output logic          o_wb_we,
	output reg_idx_t      o_wb_rd,
	output word_t         o_wb_data
);

	word_t   wb_alu;
	word_t   wb_load;
	word_t   wb_link;
	wb_src_t wb_src;

	// data port straight from EX/MEM, memory answers this cycle
	assign o_data_address = i_alu_result;
	assign o_write_data   = i_store_data;
	assign o_mem_read_en  = i_mem_read;
	assign o_mem_write_en = i_mem_write;

	assign o_mem_rd   = i_rd;
	assign o_mem_we   = i_reg_write;
	assign o_mem_load = i_mem_read;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_wb_we <= 1'b0;
		end else begin
			o_wb_we <= i_reg_write;
		end
	end

	always_ff @(posedge i_clk) begin
		wb_alu  <= i_alu_result;
		wb_load <= i_read_data;
		wb_link <= i_link;
		wb_src  <= i_wb_src;
		o_wb_rd <= i_rd;
	end

	// writeback select
	always_comb begin
		case (wb_src)
			WB_MEM:  o_wb_data = wb_load;
			WB_LINK: o_wb_data = wb_link;
			default: o_wb_data = wb_alu;
		endcase
	end

	a_rd_wr_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(o_mem_read_en && o_mem_write_en))
		else $error("mem_stage: read and write enabled together");

endmodule

`default_nettype wire

// File: verilog/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	// primary opcode field, bits 31:26
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_JAL   = 6'h03;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_BNE   = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI  = 6'h0a;
	localparam logic [5:0] OP_ANDI  = 6'h0c;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_XORI  = 6'h0e;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;

	// funct field of R-type, bits 5:0
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	// jal writes its link here
	localparam reg_idx_t REG_LINK = 5'd31;

	localparam word_t NOP_WORD = 32'h0000_0000;
	localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire
